// File: all.f
+incdir+rtl
rtl/uart_pkg.sv
rtl/wb_pkg.sv
rtl/uart_ifs.sv
rtl/uart_regs.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_top.sv
test/uart_tb.sv

// File: Bender.yml
package:
  name: uart_wb

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/uart_pkg.sv
      - rtl/wb_pkg.sv
      - rtl/uart_ifs.sv
      - rtl/uart_regs.sv
      - rtl/uart_tx.sv
      - rtl/uart_rx.sv
      - rtl/uart_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/uart_tb.sv

// File: test/uart_golden.txt
# columns: op operand expected, numbers in hex
# W adr data, R adr value, SEND byte tx_low_cycles (0 skips), RXBITS byte stop_bit
# reset state
R 1 0
R 2 14
R 3 0
# divisor readback and start bit timing
W 2 18
R 2 18
SEND 55 18
WAITIDLE 0 0
WAITVALID 0 0
R 0 55
R 1 0
W 2 10
R 2 10
SEND 34 30
WAITIDLE 0 0
WAITVALID 0 0
R 0 34
R 1 0
W 2 14
R 2 14
# loopback
SEND a7 14
WAITIDLE 0 0
WAITVALID 0 0
R 0 a7
R 1 0
SEND 80 a0
WAITIDLE 0 0
WAITVALID 0 0
R 0 80
R 1 0
# back-pressure, second write right behind the first
SEND 5a 0
W 0 a5
WAITVALID 0 0
R 0 5a
WAITVALID 0 0
R 0 a5
WAITIDLE 0 0
R 1 0
# overrun
SEND 3c 0
W 0 c3
WAITIDLE 0 0
R 1 9
R 0 3c
R 1 8
W 1 8
R 1 0
# framing
RXBITS 96 0
WAITVALID 0 0
R 1 5
R 0 96
W 1 4
R 1 0
RXBITS 69 1
WAITVALID 0 0
R 1 1
R 0 69
R 1 0

// File: test/uart_tb.sv
// self-checking testbench that runs the golden script against uart_top over bus and serial line
`default_nettype none
`include "uart_consts.svh"

module uart_tb import uart_pkg::*, wb_pkg::*;;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT = 20000;  // cycles allowed per wait
  localparam int PADS    = 4;

  logic     clk;
  logic     resetq;
  logic     wb_cyc;
  logic     wb_stb;
  logic     wb_we;
  wb_addr_t wb_adr;
  wb_word_t wb_dat_w;
  wb_word_t wb_dat_r;
  logic     wb_ack;
  logic     rx;
  logic     tx;
  logic     use_bang;       // rx from the bit-banged line instead of tx
  logic     bang;
  int       cycle;
  int       ack_cycle;
  int       ack_wait;
  wb_word_t ack_data;       // read data captured with ack
  int       last_wr_cycle;
  int       frame_div;      // divisor of the frame in flight
  int       cur_div;
  bit       frame_sent;
  integer   seed;

  assign rx = use_bang ? bang : tx;  // loopback unless bit-banging

  uart_top dut_i (
    .clk      (clk),
    .resetq   (resetq),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .rx       (rx),
    .tx       (tx)
  );

  always #50 clk = ~clk;

  always @(posedge clk)
    cycle <= cycle + 1;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input wb_word_t exp, input wb_word_t got);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, got);
      abort_run($sformatf("%s did not match", name));
    end
  endtask

  task automatic check_status(input string name, input status_t exp, input status_t got);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, got);
      abort_run($sformatf("%s did not match", name));
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, got);
      abort_run($sformatf("%s did not match", name));
    end
  endtask

  // drive one access and wait for ack on the falling edge
  task automatic bus_cycle(input logic we, input wb_addr_t adr, input wb_word_t data);
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= data;
    ack_wait = 0;
    @(negedge clk);
    while (!wb_ack) begin
      if (ack_wait == TIMEOUT)
        abort_run($sformatf("no ack for the access to register %0d", adr));
      ack_wait++;
      @(negedge clk);
    end
    ack_cycle = cycle;
    ack_data  = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_write(input wb_addr_t adr, input wb_word_t data);
    bus_cycle(1'b1, adr, data);
    if (adr != REG_DATA && ack_wait != 1)
      abort_run($sformatf("write to register %0d not acked in the next cycle", adr));
  endtask

  task automatic wb_read(input wb_addr_t adr, output wb_word_t data);
    bus_cycle(1'b0, adr, '0);
    data = ack_data;
    if (ack_wait != 1)
      abort_run($sformatf("read of register %0d not acked in the next cycle", adr));
  endtask

  // a new frame may not start before the last one has run 10 bit periods
  task automatic data_write(input logic [7:0] b);
    int gap;
    wb_write(REG_DATA, wb_word_t'(b));
    gap = ack_cycle - last_wr_cycle;
    if (frame_sent && gap < 10 * frame_div)
      abort_run($sformatf("DATA write acked %0d cycles after the last one, frame not done", gap));
    frame_sent    = 1'b1;
    last_wr_cycle = ack_cycle;
    frame_div     = cur_div;
  endtask

  // cycles that tx stays low for the start bit and leading zero data bits
  function automatic int low_run(input logic [7:0] b, input int div);
    int n;
    int i;
    n = 1;
    i = 0;
    while (i < 8 && b[i] == 1'b0) begin
      n++;
      i++;
    end
    return n * div;
  endfunction

  task automatic measure_low(input wb_word_t exp);
    int n;
    int t;
    n = 0;
    t = 0;
    @(negedge clk);
    while (tx) begin
      if (t == TIMEOUT)
        abort_run("tx never went low for the start bit");
      t++;
      @(negedge clk);
    end
    while (!tx) begin
      if (n == TIMEOUT)
        abort_run("tx stayed low and never returned high");
      n++;
      @(negedge clk);
    end
    check_word("tx low time in cycles", exp, wb_word_t'(n));
  endtask

  task automatic send_byte(input logic [7:0] b, input wb_word_t run);
    data_write(b);
    if (run != 0)
      measure_low(run);
  endtask

  // poll STATUS until one flag reaches the wanted level
  task automatic poll_status(input int idx, input logic want, input string what);
    wb_word_t w;
    int t0;
    t0 = cycle;
    wb_read(REG_STATUS, w);
    while (w[idx] !== want) begin
      if (cycle - t0 > TIMEOUT)
        abort_run(what);
      wb_read(REG_STATUS, w);
    end
  endtask

  task automatic bang_frame(input logic [7:0] b, input logic stop_bit);
    logic [9:0] bits;
    int i;
    bits = {stop_bit, b, 1'b0};  // sent LSB first
    @(posedge clk);
    use_bang <= 1'b1;
    for (i = 0; i < 10; i++) begin
      bang <= bits[i];
      repeat (cur_div) @(posedge clk);
    end
    bang <= 1'b1;
    repeat (2 * cur_div) @(posedge clk);
    use_bang <= 1'b0;
  endtask

  task automatic run_step(input logic [8*10-1:0] op, input wb_word_t arg, input wb_word_t exp);
    wb_word_t got;
    if (op == "W") begin
      if (arg[1:0] == REG_DATA) begin
        data_write(exp[7:0]);
      end else begin
        wb_write(arg[1:0], exp);
        if (arg[1:0] == REG_DIV)
          cur_div = exp[15:0];  // next frame uses it
      end
    end else if (op == "R") begin
      wb_read(arg[1:0], got);
      if (arg[1:0] == REG_DATA)
        check_byte("DATA", exp[7:0], got[7:0]);
      else if (arg[1:0] == REG_STATUS)
        check_status("STATUS", status_t'(exp[3:0]), status_t'(got[3:0]));
      else
        check_word($sformatf("register %0d", arg[1:0]), exp, got);
    end else if (op == "SEND") begin
      send_byte(arg[7:0], exp);
    end else if (op == "RXBITS") begin
      bang_frame(arg[7:0], exp[0]);
    end else if (op == "WAITVALID") begin
      poll_status(0, 1'b1, "rx_valid did not rise within the timeout");
    end else if (op == "WAITIDLE") begin
      poll_status(1, 1'b0, "tx_busy did not drop within the timeout");
    end else begin
      abort_run($sformatf("unknown opcode %0s in the golden file", op));
    end
  endtask

  initial begin
    int fd;
    int code;
    int i;
    logic [8*10-1:0] op;
    logic [8*128-1:0] line;
    wb_word_t arg;
    wb_word_t exp;
    wb_word_t got;
    logic [7:0] b;
    clk        = 1'b0;
    resetq     = 1'b0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat_w   = '0;
    use_bang   = 1'b0;
    bang       = 1'b1;
    cycle      = 0;
    frame_sent = 1'b0;
    cur_div    = `UART_DIV_RESET;
    seed       = 32'h9bad;
    repeat (10) @(posedge clk);
    resetq <= 1'b1;
    @(negedge clk);
    check_word("tx", 32'd1, wb_word_t'(tx));

    fd = $fopen("test/uart_golden.txt", "r");
    if (fd == 0)
      abort_run("cannot open test/uart_golden.txt");
    code = $fscanf(fd, "%s", op);
    while (code == 1) begin
      if (op == "#") begin
        code = $fgets(line, fd);  // skip comment
      end else begin
        code = $fscanf(fd, "%h %h", arg, exp);
        if (code != 2)
          abort_run($sformatf("golden line for %0s is missing its operands", op));
        run_step(op, arg, exp);
      end
      code = $fscanf(fd, "%s", op);
    end
    $fclose(fd);

    // random pad bytes in loopback
    for (i = 0; i < PADS; i++) begin
      b = 8'($random(seed));
      send_byte(b, wb_word_t'(low_run(b, cur_div)));
      poll_status(1, 1'b0, "tx_busy did not drop within the timeout");
      poll_status(0, 1'b1, "rx_valid did not rise within the timeout");
      wb_read(REG_DATA, got);
      check_byte("DATA", b, got[7:0]);
      wb_read(REG_STATUS, got);
      check_status("STATUS", '0, status_t'(got[3:0]));
    end

    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/uart_top.sv
// UART top level, Wishbone slave and serial pins, wiring the registers to tx and rx
`default_nettype none

module uart_top import wb_pkg::*; (
  input  logic     clk,
  input  logic     resetq,
  input  logic     wb_cyc,
  input  logic     wb_stb,
  input  logic     wb_we,
  input  wb_addr_t wb_adr,
  input  wb_word_t wb_dat_w,
  output wb_word_t wb_dat_r,
  output logic     wb_ack,
  input  logic     rx,
  output logic     tx
);

  uart_tx_if tx_link ();
  uart_rx_if rx_link ();

  uart_regs u_regs (
    .clk      (clk),
    .resetq   (resetq),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .txp      (tx_link.regs),
    .rxp      (rx_link.regs)
  );

  uart_tx u_tx (
    .clk    (clk),
    .resetq (resetq),
    .txp    (tx_link.tx),
    .tx     (tx)
  );

  uart_rx u_rx (
    .clk    (clk),
    .resetq (resetq),
    .rx     (rx),
    .rxp    (rx_link.rx)
  );

endmodule

`default_nettype wire

// File: rtl/uart_rx.sv
// 8N1 receiver: synchronizes rx, times half bits from the start edge and samples mid-bit
`default_nettype none

module uart_rx import uart_pkg::*; (
  input  logic  clk,
  input  logic  resetq,
  input  logic  rx,
  uart_rx_if.rx rxp
);

  logic       rx_meta;
  logic       rx_sync;
  logic       rx_prev;
  logic       idle;
  logic       start;
  logic       tick;       // end of a half bit
  logic       sample;     // middle of a data bit
  logic       stop;       // middle of the stop bit
  logic [4:0] phase;      // half bits since the start edge, all ones when idle
  logic [4:0] phase_n;
  divisor_t   hcnt;
  divisor_t   half_q;     // half the divisor, latched at the start edge
  logic [7:0] shifter;
  logic [7:0] data_q;
  logic       valid_q;

  assign idle    = &phase;
  assign start   = idle & rx_prev & ~rx_sync;
  assign tick    = (hcnt == half_q - divisor_t'(1));
  assign phase_n = phase + 5'd1;

  // odd phases 3 to 17 land mid data bit
  assign sample = tick & ~idle & phase_n[0] & (phase_n >= 5'd3) & (phase_n <= 5'd17);
  assign stop   = tick & ~idle & (phase_n == 5'd19);

  assign rxp.data  = data_q;
  assign rxp.valid = valid_q;

  // two-flop synchronizer plus one for the edge
  always_ff @(posedge clk) begin
    if (!resetq) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // half-bit timer and phase
  always_ff @(posedge clk) begin
    if (!resetq) begin
      hcnt  <= '0;
      phase <= 5'b11111;
    end else if (start) begin
      hcnt  <= '0;     // realign to the edge
      phase <= 5'd0;
    end else begin
      hcnt <= tick ? '0 : hcnt + divisor_t'(1);
      if (stop)
        phase <= 5'b11111;
      else if (tick & ~idle)
        phase <= phase_n;
    end
  end

  // byte hand-off and error events
  always_ff @(posedge clk) begin
    if (!resetq) begin
      valid_q           <= 1'b0;
      rxp.frame_pulse   <= 1'b0;
      rxp.overrun_pulse <= 1'b0;
    end else begin
      rxp.frame_pulse   <= stop & ~rx_sync;  // stop bit low
      rxp.overrun_pulse <= stop & valid_q & ~rxp.rd;
      if (stop)
        valid_q <= 1'b1;
      else if (rxp.rd)
        valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start)
      half_q <= rxp.div >> 1;
    if (sample)
      shifter <= {rx_sync, shifter[7:1]};  // LSB arrives first
    if (stop & (~valid_q | rxp.rd))
      data_q <= shifter;  // unread byte stays on overrun
  end

endmodule

`default_nettype wire

// File: rtl/uart_tx.sv
// 8N1 transmitter, starts a frame on each wr strobe and times every bit from the divisor
`default_nettype none

module uart_tx import uart_pkg::*; (
  input  logic  clk,
  input  logic  resetq,
  uart_tx_if.tx txp,
  output logic  tx
);

  logic [3:0] bit_cnt;  // bits left in the frame, 0 when idle
  logic [8:0] shifter;  // data LSB first, then the stop bit
  divisor_t   cnt;      // cycles into the current bit
  divisor_t   div_q;    // divisor latched for this frame
  logic       wrap;

  assign wrap     = (cnt == div_q - divisor_t'(1));
  assign txp.busy = |bit_cnt;

  // line, bit counter and bit timer
  always_ff @(posedge clk) begin
    if (!resetq) begin
      tx      <= 1'b1;
      bit_cnt <= '0;
      cnt     <= '0;
    end else if (txp.wr) begin
      tx      <= 1'b0;   // start bit right away
      bit_cnt <= 4'd10;  // start, 8 data, stop
      cnt     <= '0;
    end else if (txp.busy) begin
      if (wrap) begin
        cnt     <= '0;
        tx      <= shifter[0];
        bit_cnt <= bit_cnt - 4'd1;
      end else begin
        cnt <= cnt + divisor_t'(1);
      end
    end
  end

  // frame contents
  always_ff @(posedge clk) begin
    if (txp.wr) begin
      shifter <= {1'b1, txp.data};
      div_q   <= txp.div;  // a new divisor only takes effect here
    end else if (txp.busy & wrap) begin
      shifter <= {1'b1, shifter[8:1]};  // idle high behind the stop bit
    end
  end

endmodule

`default_nettype wire

// File: rtl/uart_regs.sv
// Wishbone classic slave with the data, status and divisor registers that steer tx and rx
`default_nettype none
`include "uart_consts.svh"

module uart_regs import uart_pkg::*, wb_pkg::*; (
  input  logic         clk,
  input  logic         resetq,
  input  logic         wb_cyc,
  input  logic         wb_stb,
  input  logic         wb_we,
  input  wb_addr_t     wb_adr,
  input  wb_word_t     wb_dat_w,
  output wb_word_t     wb_dat_r,
  output logic         wb_ack,
  uart_tx_if.regs      txp,
  uart_rx_if.regs      rxp
);

  logic       req;
  logic       done;       // access acked and waiting for stb to drop
  logic       tx_block;   // data write must wait for the transmitter
  logic       go;         // ack this access now
  logic       is_data;
  logic       is_status;
  logic       is_div;
  logic [7:0] tx_data;
  logic       frame_err;
  logic       overrun;
  divisor_t   div;
  status_t    st;
  status_t    w1c;

  assign req       = wb_cyc & wb_stb;
  assign is_data   = (wb_adr == REG_DATA);
  assign is_status = (wb_adr == REG_STATUS);
  assign is_div    = (wb_adr == REG_DIV);

  assign tx_block = wb_we & is_data & txp.busy;
  assign go       = req & ~done & ~tx_block;

  assign w1c = status_t'(wb_dat_w[3:0]);
  assign st  = '{overrun: overrun, frame_err: frame_err,
                 tx_busy: txp.busy, rx_valid: rxp.valid};

  assign txp.data = tx_data;
  assign txp.div  = div;
  assign rxp.div  = div;

  // bus handshake and the strobes that ride on ack
  always_ff @(posedge clk) begin
    if (!resetq) begin
      wb_ack <= 1'b0;
      done   <= 1'b0;
      txp.wr <= 1'b0;
      rxp.rd <= 1'b0;
    end else begin
      wb_ack <= go;
      txp.wr <= go & wb_we & is_data;
      rxp.rd <= go & ~wb_we & is_data;
      if (go)
        done <= 1'b1;
      else if (!req)
        done <= 1'b0;  // stb was low for a cycle so ready again
    end
  end

  // sticky error bits and divisor
  always_ff @(posedge clk) begin
    if (!resetq) begin
      frame_err <= 1'b0;
      overrun   <= 1'b0;
      div       <= divisor_t'(`UART_DIV_RESET);
    end else begin
      if (rxp.frame_pulse)
        frame_err <= 1'b1;  // new event beats a clear
      else if (go & wb_we & is_status & w1c.frame_err)
        frame_err <= 1'b0;
      if (rxp.overrun_pulse)
        overrun <= 1'b1;
      else if (go & wb_we & is_status & w1c.overrun)
        overrun <= 1'b0;
      if (go & wb_we & is_div)
        div <= wb_dat_w[15:0];
    end
  end

  // transmit byte and read data
  always_ff @(posedge clk) begin
    if (go & wb_we & is_data)
      tx_data <= wb_dat_w[7:0];
    if (go & ~wb_we) begin
      case (reg_addr_e'(wb_adr))
        REG_DATA:   wb_dat_r <= {24'd0, rxp.data};
        REG_STATUS: wb_dat_r <= {28'd0, st};
        REG_DIV:    wb_dat_r <= {16'd0, div};
        default:    wb_dat_r <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/uart_ifs.sv
// links from the register block to the transmitter and from the receiver back to the registers
`default_nettype none

interface uart_tx_if import uart_pkg::*;;
  logic [7:0] data;   // byte to send
  logic       wr;     // one-cycle start strobe
  divisor_t   div;    // cycles per bit
  logic       busy;   // frame in progress

  modport regs (
    output data, wr, div,
    input  busy
  );

  modport tx (
    input  data, wr, div,
    output busy
  );
endinterface

interface uart_rx_if import uart_pkg::*;;
  logic [7:0] data;           // last received byte
  logic       valid;          // byte waiting to be read
  logic       rd;             // one-cycle read strobe
  logic       frame_pulse;    // stop bit came in low
  logic       overrun_pulse;  // frame dropped, old byte unread
  divisor_t   div;            // cycles per bit, halved in the receiver

  modport regs (
    input  data, valid, frame_pulse, overrun_pulse,
    output rd, div
  );

  modport rx (
    output data, valid, frame_pulse, overrun_pulse,
    input  rd, div
  );
endinterface

`default_nettype wire

// File: rtl/wb_pkg.sv
// bus-side types of the UART, shared by the Wishbone slave, the top level and the testbench
`default_nettype none

package wb_pkg;

  typedef logic [31:0] wb_word_t;  // bus data word
  typedef logic [1:0] wb_addr_t;   // word address

  // register map, address 3 reads as zero
  typedef enum wb_addr_t {
    REG_DATA   = 2'd0,
    REG_STATUS = 2'd1,
    REG_DIV    = 2'd2
  } reg_addr_e;

endpackage

`default_nettype wire

// File: rtl/uart_pkg.sv
// line-side types of the UART, imported by the interfaces, the shifters and the register block
`default_nettype none

package uart_pkg;

  // clock cycles per serial bit
  typedef logic [15:0] divisor_t;

  // status word, bit 0 upward: rx_valid, tx_busy, frame_err, overrun
  typedef struct packed {
    logic overrun;    // bit 3, sticky
    logic frame_err;  // bit 2, sticky
    logic tx_busy;    // bit 1
    logic rx_valid;   // bit 0
  } status_t;

endpackage

`default_nettype wire

// File: rtl/uart_consts.svh
// clock, line rate and reset divisor for the UART, included by the register block and testbench
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// system clock in Hz
`define UART_CLKFREQ 10_000_000

// line rate after reset, in bits per second
`define UART_BAUD 500_000

// clock cycles per bit at the reset line rate
`define UART_DIV_RESET (`UART_CLKFREQ / `UART_BAUD)

`endif
